// File: rv_core.f
src/riscv_pkg.sv
src/mem_req_if.sv
src/core_fsm.sv
src/xfer_counter.sv
src/mem_port.sv
src/inst_decode.sv
src/exec_unit.sv
src/reg_file.sv
src/cpu.sv
dv/tb_clk_gen.sv
dv/cpu_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - src/riscv_pkg.sv
  - src/mem_req_if.sv
  - src/core_fsm.sv
  - src/xfer_counter.sv
  - src/mem_port.sv
  - src/inst_decode.sv
  - src/exec_unit.sv
  - src/reg_file.sv
  - src/cpu.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/cpu_tb.sv

// File: dv/cpu_tb.sv
/* cpu_tb: byte memory model, table of one-instruction programs and write
   checks for the rv_core cpu, run once plain and once with random stalls */
`timescale 1ns/100ps

module cpu_tb import riscv_pkg::*; ();

    localparam int MEM_BYTES        = 128 * 1024;
    localparam int MAX_ROWS         = 48;
    localparam int CYCLES_PER_INSTR = 20;
    // loads of x1 and x2, test, skip slot, store, jal
    localparam int INSTR_PER_ROW    = 8;

    logic  clk;
    logic  rst_n;
    logic  restart;
    logic  rdy;
    byte_t mem_din;
    byte_t mem_dout;
    word_t mem_a;
    logic  mem_wr;

    byte_t mem [MEM_BYTES];
    word_t bus_a;
    byte_t bus_dout;
    logic  bus_wr;
    byte_t rd_byte;
    word_t wr_addr_q [$];
    byte_t wr_data_q [$];

    word_t row_inst [MAX_ROWS];
    word_t row_a [MAX_ROWS];
    word_t row_b [MAX_ROWS];
    word_t row_exp [MAX_ROWS];
    int    row_nb [MAX_ROWS];
    int    num_rows;
    int    cur_row;

    logic        stall_en;
    logic [31:0] seed;
    logic [31:0] rnd;
    int          cycles;
    int          cycle_limit;
    int          checks;
    int          value_errs;
    int          other_errs;

    tb_clk_gen clk_gen0 (.restart_i(restart), .clk_o(clk), .rst_n_o(rst_n));

    cpu dut0 (
        .clk_in(clk), .rst_n_i(rst_n), .rdy_i(rdy),
        .mem_din_i(mem_din), .mem_dout_o(mem_dout),
        .mem_a_o(mem_a), .mem_wr_o(mem_wr)
    );

    function automatic word_t alu_rr(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, OP_REG};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    // compares x1 with x2
    function automatic word_t b_type(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                     input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t j_type(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic put_word(input word_t addr, input word_t w);
        for (int k = 0; k < 4; k++) begin
            mem[addr + word_t'(k)] = w[8*k +: 8];
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] row %0d %s: got %h, expected %h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] row %0d %s: got %h, expected %h", cur_row, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("row %0d: %s", cur_row, what);
    endtask

    task automatic add_row(input word_t inst, input word_t a, input word_t b,
                           input word_t exp, input int nb);
        row_inst[num_rows] = inst;
        row_a[num_rows]    = a;
        row_b[num_rows]    = b;
        row_exp[num_rows]  = exp;
        row_nb[num_rows]   = nb;
        num_rows++;
    endtask

    task automatic build_table();
        // register-register
        add_row(alu_rr(7'h00, 3'b000), 32'h1234_5678, 32'h0fed_cba9, 32'h2222_2221, 4);
        add_row(alu_rr(7'h20, 3'b000), 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe, 4);
        add_row(alu_rr(7'h00, 3'b001), 32'h8000_0001, 32'h0000_0004, 32'h0000_0010, 4);
        add_row(alu_rr(7'h00, 3'b010), 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 4);
        add_row(alu_rr(7'h00, 3'b011), 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 4);
        add_row(alu_rr(7'h00, 3'b100), 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0, 4);
        add_row(alu_rr(7'h00, 3'b101), 32'h8000_0000, 32'h0000_0024, 32'h0800_0000, 4);
        add_row(alu_rr(7'h20, 3'b101), 32'h8000_0000, 32'h0000_0004, 32'hf800_0000, 4);
        add_row(alu_rr(7'h00, 3'b110), 32'h0000_f00f, 32'h00ff_0000, 32'h00ff_f00f, 4);
        add_row(alu_rr(7'h00, 3'b111), 32'h1234_5678, 32'hff00_ff00, 32'h1200_5600, 4);
        // register-immediate
        add_row(i_type(12'hfff, 5'd1, 3'b000, 5'd3, OP_IMM), 32'h0, 32'h0, 32'hffff_ffff, 4);
        add_row(i_type(12'hffb, 5'd1, 3'b010, 5'd3, OP_IMM), 32'hffff_fffa, 32'h0, 32'h1, 4);
        add_row(i_type(12'hfff, 5'd1, 3'b011, 5'd3, OP_IMM), 32'h0000_0005, 32'h0, 32'h1, 4);
        add_row(i_type(12'h7ff, 5'd1, 3'b100, 5'd3, OP_IMM), 32'h0000_ffff, 32'h0,
                32'h0000_f800, 4);
        add_row(i_type(12'hff0, 5'd1, 3'b111, 5'd3, OP_IMM), 32'h1234_5678, 32'h0,
                32'h1234_5670, 4);
        add_row(i_type(12'h01f, 5'd1, 3'b001, 5'd3, OP_IMM), 32'h0000_0003, 32'h0,
                32'h8000_0000, 4);
        add_row(i_type(12'h008, 5'd1, 3'b101, 5'd3, OP_IMM), 32'h8765_4321, 32'h0,
                32'h0087_6543, 4);
        add_row(i_type(12'h408, 5'd1, 3'b101, 5'd3, OP_IMM), 32'h8765_4321, 32'h0,
                32'hff87_6543, 4);
        // upper immediates, auipc sits at pc 0x10
        add_row(u_type(20'habcde, 5'd3, OP_LUI), 32'h0, 32'h0, 32'habcd_e000, 4);
        add_row(u_type(20'h00001, 5'd3, OP_AUIPC), 32'h0, 32'h0, 32'h0000_1010, 4);
        // taken branches skip the increment, x3 stays 0
        add_row(b_type(13'd8, 3'b000), 32'h0000_0055, 32'h0000_0055, 32'h0, 4);
        add_row(b_type(13'd8, 3'b001), 32'h0000_0001, 32'h0000_0001, 32'h1, 4);
        add_row(b_type(13'd8, 3'b100), 32'hffff_ffff, 32'h0000_0000, 32'h0, 4);
        add_row(b_type(13'd8, 3'b101), 32'hffff_ffff, 32'h0000_0000, 32'h1, 4);
        add_row(b_type(13'd8, 3'b110), 32'hffff_ffff, 32'h0000_0000, 32'h1, 4);
        add_row(b_type(13'd8, 3'b111), 32'hffff_ffff, 32'h0000_0000, 32'h0, 4);
        // jumps land on the store at 0x18, link is 0x14
        add_row(j_type(21'd8, 5'd3), 32'h0, 32'h0, 32'h0000_0014, 4);
        add_row(i_type(12'h005, 5'd1, 3'b000, 5'd3, OP_JALR), 32'h0000_0014, 32'h0,
                32'h0000_0014, 4);
        // preset bytes at 0x200 are 81 7e c3 a5
        add_row(i_type(12'h000, 5'd1, 3'b000, 5'd3, OP_LOAD), 32'h200, 32'h0, 32'hffff_ff81, 4);
        add_row(i_type(12'h000, 5'd1, 3'b100, 5'd3, OP_LOAD), 32'h200, 32'h0, 32'h0000_0081, 4);
        add_row(i_type(12'h001, 5'd1, 3'b000, 5'd3, OP_LOAD), 32'h200, 32'h0, 32'h0000_007e, 4);
        add_row(i_type(12'h002, 5'd1, 3'b001, 5'd3, OP_LOAD), 32'h200, 32'h0, 32'hffff_a5c3, 4);
        add_row(i_type(12'h002, 5'd1, 3'b101, 5'd3, OP_LOAD), 32'h200, 32'h0, 32'h0000_a5c3, 4);
        add_row(i_type(12'h000, 5'd1, 3'b010, 5'd3, OP_LOAD), 32'h200, 32'h0, 32'ha5c3_7e81, 4);
        // narrow stores of x3
        add_row(i_type(12'h000, 5'd1, 3'b000, 5'd3, OP_IMM), 32'hdead_beef, 32'h0,
                32'hdead_beef, 1);
        add_row(alu_rr(7'h00, 3'b000), 32'h0000_1234, 32'h0000_5678, 32'h0000_68ac, 2);
    endtask

    task automatic run_row(input int r);
        word_t      a_adj;
        word_t      b_adj;
        word_t      pc;
        word_t      st_addr;
        word_t      jal_addr;
        logic [2:0] st_f3;
        int         n_wr;
        cur_row = r;
        @(negedge clk);
        restart = 1'b1;
        // program is written while the core is held in reset
        a_adj = row_a[r] + 32'h800;
        b_adj = row_b[r] + 32'h800;
        put_word(32'h00, u_type(a_adj[31:12], 5'd1, OP_LUI));
        put_word(32'h04, i_type(row_a[r][11:0], 5'd1, 3'b000, 5'd1, OP_IMM));
        put_word(32'h08, u_type(b_adj[31:12], 5'd2, OP_LUI));
        put_word(32'h0c, i_type(row_b[r][11:0], 5'd2, 3'b000, 5'd2, OP_IMM));
        put_word(32'h10, row_inst[r]);
        pc = 32'h14;
        if (row_inst[r][6:0] == OP_BRANCH || row_inst[r][6:0] == OP_JAL ||
            row_inst[r][6:0] == OP_JALR) begin
            put_word(pc, i_type(12'h001, 5'd3, 3'b000, 5'd3, OP_IMM));
            pc = pc + 32'd4;
        end
        st_f3   = (row_nb[r] == 1) ? 3'b000 : (row_nb[r] == 2) ? 3'b001 : 3'b010;
        st_addr = 32'h100 + word_t'(4 - row_nb[r]);
        put_word(pc, s_type(st_addr[11:0], 5'd3, 5'd0, st_f3));
        jal_addr = pc + 32'd4;
        put_word(jal_addr, j_type(21'd0, 5'd0));
        wr_addr_q.delete();
        wr_data_q.delete();
        @(negedge clk);
        restart = 1'b0;
        @(posedge rst_n);
        @(negedge clk);
        check_addr("mem_a_o", mem_a, 32'h0);
        if (mem_wr !== 1'b0) begin
            report_failure("mem_wr_o is high in the first cycle after reset");
        end
        // first fetch of the closing jal means the store has finished
        while (!(mem_a === jal_addr && mem_wr === 1'b0)) begin
            @(negedge clk);
        end
        n_wr = wr_addr_q.size();
        if (n_wr != row_nb[r]) begin
            report_failure($sformatf("%0d bytes written, %0d expected", n_wr, row_nb[r]));
        end
        for (int i = 0; i < n_wr && i < row_nb[r]; i++) begin
            check_addr("mem_a_o", wr_addr_q[i], st_addr + word_t'(i));
            check_byte("mem_dout_o", wr_data_q[i], row_exp[r][8*i +: 8]);
        end
    endtask

    // memory acts on the bus value seen in the cycle now ending
    always @(posedge clk) begin
        if (rdy) begin
            rd_byte <= mem[bus_a[16:0]];
            if (bus_wr) begin
                mem[bus_a[16:0]] <= bus_dout;
                wr_addr_q.push_back(bus_a);
                wr_data_q.push_back(bus_dout);
            end
        end
    end

    always @(negedge clk) begin
        bus_a    <= mem_a;
        bus_dout <= mem_dout;
        bus_wr   <= mem_wr;
        mem_din  <= rd_byte;
        if (!rst_n && mem_wr !== 1'b0) begin
            report_failure("mem_wr_o is high while reset is asserted");
        end
    end

    always @(negedge clk) begin
        rnd = $random(seed);
        rdy = !stall_en || (rnd[1:0] != 2'b00);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        restart     = 1'b0;
        stall_en    = 1'b0;
        rdy         = 1'b1;
        mem_din     = '0;
        rd_byte     = '0;
        seed        = 32'hed4c_23c5;
        cycles      = 0;
        checks      = 0;
        value_errs  = 0;
        other_errs  = 0;
        num_rows    = 0;
        cur_row     = -1;
        cycle_limit = 1 << 30;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = byte_t'(a ^ (a >> 8) ^ (a >> 16));
        end
        put_word(32'h200, 32'ha5c3_7e81);
        build_table();
        cycle_limit = CYCLES_PER_INSTR * INSTR_PER_ROW * num_rows * 2;
        @(posedge rst_n);
        for (int pass = 0; pass < 2; pass++) begin
            stall_en = (pass == 1);
            for (int r = 0; r < num_rows; r++) begin
                run_row(r);
            end
        end
        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: dv/tb_clk_gen.sv
/* tb_clk_gen: 10 ns testbench clock, and a 16-cycle reset at start
   and again on each restart request */
`timescale 1ns/100ps

module tb_clk_gen (
    input  logic restart_i,
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // release on a falling edge, next to the other driven inputs
    initial begin
        rst_n_o = 1'b0;
        forever begin
            repeat (16) @(posedge clk_o);
            @(negedge clk_o);
            rst_n_o = 1'b1;
            @(posedge restart_i);
            rst_n_o = 1'b0;
        end
    end

endmodule

// File: src/cpu.sv
/* cpu: multi-cycle RV32I core on a byte-wide memory bus, frozen while
   rdy_i is low */
`timescale 1ns/100ps

module cpu import riscv_pkg::*; (
    input  logic  clk_in,
    input  logic  rst_n_i,
    input  logic  rdy_i,
    input  byte_t mem_din_i,
    output byte_t mem_dout_o,
    output word_t mem_a_o,
    output logic  mem_wr_o
);

    mem_req_if req ();

    inst_u      ir;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm;
    alu_op_e    alu_op;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       is_load;
    logic       is_store;
    logic       writes_rd;
    mem_len_e   len;
    logic       sgn;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      rd_val;
    logic       ir_we;
    logic       pc_we;
    logic       rd_we;
    logic       xfer_load;
    logic       xfer_write;
    mem_len_e   xfer_len;
    logic       issue;
    logic [1:0] issue_idx;
    logic       capture;
    logic [1:0] capture_idx;
    logic       last;

    core_fsm fsm0 (
        .clk_in(clk_in), .rst_n_i(rst_n_i), .rdy_i(rdy_i),
        .req(req.core_mp),
        .is_load_i(is_load), .is_store_i(is_store),
        .len_i(len), .sgn_i(sgn),
        .ir_we_o(ir_we), .pc_we_o(pc_we), .rd_we_o(rd_we)
    );

    mem_port port0 (
        .clk_in(clk_in), .rst_n_i(rst_n_i), .rdy_i(rdy_i),
        .req(req.port_mp),
        .load_o(xfer_load), .write_o(xfer_write), .len_o(xfer_len),
        .issue_i(issue), .issue_idx_i(issue_idx),
        .capture_i(capture), .capture_idx_i(capture_idx), .last_i(last),
        .mem_din_i(mem_din_i), .mem_dout_o(mem_dout_o),
        .mem_a_o(mem_a_o), .mem_wr_o(mem_wr_o)
    );

    xfer_counter cnt0 (
        .clk_in(clk_in), .rst_n_i(rst_n_i), .rdy_i(rdy_i),
        .load_i(xfer_load), .write_i(xfer_write), .len_i(xfer_len),
        .issue_o(issue), .issue_idx_o(issue_idx),
        .capture_o(capture), .capture_idx_o(capture_idx), .last_o(last)
    );

    inst_decode dec0 (
        .ir_i(ir),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd),
        .imm_o(imm), .alu_op_o(alu_op), .opcode_o(opcode), .funct3_o(funct3),
        .is_load_o(is_load), .is_store_o(is_store), .writes_rd_o(writes_rd),
        .len_o(len), .sgn_o(sgn)
    );

    exec_unit exu0 (
        .clk_in(clk_in), .rst_n_i(rst_n_i), .rdy_i(rdy_i),
        .ir_we_i(ir_we), .pc_we_i(pc_we),
        .mem_din_word_i(req.rdata),
        .imm_i(imm), .alu_op_i(alu_op), .opcode_i(opcode), .funct3_i(funct3),
        .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
        .req(req.core_mp),
        .ir_o(ir), .rd_val_o(rd_val)
    );

    // branches, stores and no-ops leave rd alone
    reg_file rf0 (
        .clk_in(clk_in), .rst_n_i(rst_n_i), .rdy_i(rdy_i),
        .we_i(rd_we && writes_rd),
        .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd),
        .rd_val_i(rd_val),
        .rs1_val_o(rs1_val), .rs2_val_o(rs2_val)
    );

endmodule

// File: src/reg_file.sv
/* reg_file: 32 general registers, two read ports and one write port */
`timescale 1ns/100ps

module reg_file import riscv_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_n_i,
    input  logic      rdy_i,
    input  logic      we_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  word_t     rd_val_i,
    output word_t     rs1_val_o,
    output word_t     rs2_val_o
);

    word_t regs_q [2**REG_ADDR_W];

    // x0 is never written, so it reads zero
    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < 2**REG_ADDR_W; k++) begin
                regs_q[k] <= '0;
            end
        end else if (rdy_i && we_i && (rd_i != '0)) begin
            regs_q[rd_i] <= rd_val_i;
        end
    end

    assign rs1_val_o = regs_q[rs1_i];
    assign rs2_val_o = regs_q[rs2_i];

endmodule

// File: src/exec_unit.sv
/* exec_unit: pc and instruction register, ALU, branch compare, next pc
   and writeback select */
`timescale 1ns/100ps

module exec_unit import riscv_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_n_i,
    input  logic       rdy_i,
    input  logic       ir_we_i,
    input  logic       pc_we_i,
    input  word_t      mem_din_word_i,
    input  word_t      imm_i,
    input  alu_op_e    alu_op_i,
    input  opcode_e    opcode_i,
    input  logic [2:0] funct3_i,
    input  word_t      rs1_val_i,
    input  word_t      rs2_val_i,
    mem_req_if.core_mp req,
    output inst_u      ir_o,
    output word_t      rd_val_o
);

    word_t pc_q;
    inst_u ir_q;
    logic  fetch_q;
    word_t link;
    word_t op_a;
    word_t op_b;
    word_t alu_res;
    word_t next_pc;
    logic  taken;

    assign link = pc_q + word_t'(4);
    assign op_a = (opcode_i inside {OP_AUIPC, OP_JAL, OP_BRANCH}) ? pc_q : rs1_val_i;
    assign op_b = (opcode_i == OP_REG) ? rs2_val_i : imm_i;

    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = word_t'(op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (funct3_i)
            3'b000:  taken = (rs1_val_i == rs2_val_i);
            3'b001:  taken = (rs1_val_i != rs2_val_i);
            3'b100:  taken = $signed(rs1_val_i) < $signed(rs2_val_i);
            3'b101:  taken = $signed(rs1_val_i) >= $signed(rs2_val_i);
            3'b110:  taken = rs1_val_i < rs2_val_i;
            3'b111:  taken = rs1_val_i >= rs2_val_i;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode_i)
            OP_JAL:    next_pc = alu_res;
            OP_JALR:   next_pc = {alu_res[XLEN-1:1], 1'b0};
            OP_BRANCH: next_pc = taken ? alu_res : link;
            default:   next_pc = link;
        endcase
    end

    always_comb begin
        case (opcode_i)
            OP_LOAD:         rd_val_o = mem_din_word_i;
            OP_JAL, OP_JALR: rd_val_o = link;
            OP_LUI:          rd_val_o = imm_i;
            default:         rd_val_o = alu_res;
        endcase
    end

    // bus address is the pc until the new instruction is latched
    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q    <= RESET_PC;
            ir_q    <= '0;
            fetch_q <= 1'b1;
        end else if (rdy_i) begin
            if (ir_we_i) begin
                ir_q    <= mem_din_word_i;
                fetch_q <= 1'b0;
            end
            if (pc_we_i) begin
                pc_q    <= next_pc;
                fetch_q <= 1'b1;
            end
        end
    end

    assign req.addr  = fetch_q ? pc_q : alu_res;
    assign req.wdata = rs2_val_i;
    assign ir_o      = ir_q;

endmodule

// File: src/inst_decode.sv
/* inst_decode: splits the instruction register into register indices,
   immediate, ALU operation and memory controls */
`timescale 1ns/100ps

module inst_decode import riscv_pkg::*; (
    input  inst_u      ir_i,
    output reg_addr_t  rs1_o,
    output reg_addr_t  rs2_o,
    output reg_addr_t  rd_o,
    output word_t      imm_o,
    output alu_op_e    alu_op_o,
    output opcode_e    opcode_o,
    output logic [2:0] funct3_o,
    output logic       is_load_o,
    output logic       is_store_o,
    output logic       writes_rd_o,
    output mem_len_e   len_o,
    output logic       sgn_o
);

    logic alt;

    assign opcode_o = opcode_e'(ir_i.r.opcode);
    assign rs1_o    = ir_i.r.rs1;
    assign rs2_o    = ir_i.r.rs2;
    assign rd_o     = ir_i.r.rd;
    assign funct3_o = ir_i.r.funct3;
    // instr bit 30 picks sub and sra
    assign alt      = ir_i.r.funct7[5];

    assign is_load_o   = (opcode_o == OP_LOAD);
    assign is_store_o  = (opcode_o == OP_STORE);
    assign writes_rd_o = opcode_o inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
                                          OP_LOAD, OP_IMM, OP_REG};
    assign len_o = mem_len_e'(ir_i.r.funct3[1:0]);
    assign sgn_o = !ir_i.r.funct3[2];

    always_comb begin
        case (opcode_o)
            OP_IMM, OP_LOAD, OP_JALR:
                imm_o = {{20{ir_i.i.imm[11]}}, ir_i.i.imm};
            OP_STORE:
                imm_o = {{20{ir_i.s.imm_hi[6]}}, ir_i.s.imm_hi, ir_i.s.imm_lo};
            OP_BRANCH:
                imm_o = {{20{ir_i.b.imm12}}, ir_i.b.imm11, ir_i.b.imm10_5,
                         ir_i.b.imm4_1, 1'b0};
            OP_LUI, OP_AUIPC:
                imm_o = {ir_i.u.imm, 12'b0};
            OP_JAL:
                imm_o = {{12{ir_i.j.imm20}}, ir_i.j.imm19_12, ir_i.j.imm11,
                         ir_i.j.imm10_1, 1'b0};
            default:
                imm_o = '0;
        endcase
    end

    // address and target sums all use add
    always_comb begin
        alu_op_o = ALU_ADD;
        if (opcode_o == OP_LUI) begin
            alu_op_o = ALU_PASS_B;
        end else if (opcode_o inside {OP_IMM, OP_REG}) begin
            case (ir_i.r.funct3)
                3'b000:  alu_op_o = (opcode_o == OP_REG && alt) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op_o = ALU_SLL;
                3'b010:  alu_op_o = ALU_SLT;
                3'b011:  alu_op_o = ALU_SLTU;
                3'b100:  alu_op_o = ALU_XOR;
                3'b101:  alu_op_o = alt ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op_o = ALU_OR;
                default: alu_op_o = ALU_AND;
            endcase
        end
    end

endmodule

// File: src/mem_port.sv
/* mem_port: drives the byte bus for one request and builds the extended
   read word from the returned bytes */
`timescale 1ns/100ps

module mem_port import riscv_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_n_i,
    input  logic       rdy_i,
    mem_req_if.port_mp req,
    output logic       load_o,
    output logic       write_o,
    output mem_len_e   len_o,
    input  logic       issue_i,
    input  logic [1:0] issue_idx_i,
    input  logic       capture_i,
    input  logic [1:0] capture_idx_i,
    input  logic       last_i,
    input  byte_t      mem_din_i,
    output byte_t      mem_dout_o,
    output word_t      mem_a_o,
    output logic       mem_wr_o
);

    word_t    raw_q;
    mem_len_e len_q;
    logic     sgn_q;

    assign load_o  = req.start;
    assign write_o = req.write;
    assign len_o   = req.len;

    assign mem_a_o    = req.addr + word_t'(issue_idx_i);
    assign mem_dout_o = req.wdata[issue_idx_i*BYTE_W +: BYTE_W];
    assign mem_wr_o   = issue_i && req.write;
    assign req.done   = last_i;

    // length and sign kept so rdata holds after done
    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            len_q <= LEN_WORD;
            sgn_q <= 1'b0;
        end else if (rdy_i && req.start) begin
            len_q <= req.len;
            sgn_q <= req.sgn;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_i && capture_i) begin
            raw_q[capture_idx_i*BYTE_W +: BYTE_W] <= mem_din_i;
        end
    end

    always_comb begin
        case (len_q)
            LEN_BYTE: req.rdata = {{(XLEN-8){sgn_q & raw_q[7]}}, raw_q[7:0]};
            LEN_HALF: req.rdata = {{(XLEN-16){sgn_q & raw_q[15]}}, raw_q[15:0]};
            default:  req.rdata = raw_q;
        endcase
    end

endmodule

// File: src/xfer_counter.sv
/* xfer_counter: counts the bytes issued and captured in one bus transfer */
`timescale 1ns/100ps

module xfer_counter import riscv_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_n_i,
    input  logic       rdy_i,
    input  logic       load_i,
    input  logic       write_i,
    input  mem_len_e   len_i,
    output logic       issue_o,
    output logic [1:0] issue_idx_o,
    output logic       capture_o,
    output logic [1:0] capture_idx_o,
    output logic       last_o
);

    logic [2:0] left_q;
    logic [1:0] idx_q;
    logic       write_q;
    logic       cap_q;
    logic [1:0] cap_idx_q;
    logic       cap_last_q;
    logic       final_issue;

    assign issue_o     = (left_q != 3'd0);
    assign issue_idx_o = idx_q;
    assign final_issue = (left_q == 3'd1);

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            left_q     <= '0;
            idx_q      <= '0;
            write_q    <= 1'b0;
            cap_q      <= 1'b0;
            cap_idx_q  <= '0;
            cap_last_q <= 1'b0;
        end else if (rdy_i) begin
            if (load_i) begin
                left_q  <= 3'd1 << len_i;
                idx_q   <= '0;
                write_q <= write_i;
            end else if (issue_o) begin
                left_q <= left_q - 3'd1;
                idx_q  <= idx_q + 2'd1;
            end
            // read data follows its address by one cycle
            cap_q      <= issue_o && !write_q;
            cap_idx_q  <= idx_q;
            cap_last_q <= issue_o && !write_q && final_issue;
        end
    end

    assign capture_o     = cap_q;
    assign capture_idx_o = cap_idx_q;
    assign last_o        = write_q ? (issue_o && final_issue) : cap_last_q;

endmodule

// File: src/core_fsm.sv
/* core_fsm: steps each instruction through fetch, decode, execute, memory
   and writeback, and issues the fetch and data transfers */
`timescale 1ns/100ps

module core_fsm import riscv_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_n_i,
    input  logic       rdy_i,
    mem_req_if.core_mp req,
    input  logic       is_load_i,
    input  logic       is_store_i,
    input  mem_len_e   len_i,
    input  logic       sgn_i,
    output logic       ir_we_o,
    output logic       pc_we_o,
    output logic       rd_we_o
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_WB
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   busy_q;
    logic   in_xfer;

    assign in_xfer = (state_q == S_FETCH) || (state_q == S_MEM);

    // one start per transfer, busy holds it off until done
    assign req.start = in_xfer && !busy_q;
    assign req.write = (state_q == S_MEM) && is_store_i;
    assign req.len   = (state_q == S_MEM) ? len_i : LEN_WORD;
    assign req.sgn   = (state_q == S_MEM) && sgn_i;

    assign ir_we_o = (state_q == S_DECODE);
    assign pc_we_o = (state_q == S_WB);
    assign rd_we_o = (state_q == S_WB);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FETCH:  if (req.done) state_d = S_DECODE;
            S_DECODE: state_d = S_EXEC;
            S_EXEC:   state_d = (is_load_i || is_store_i) ? S_MEM : S_WB;
            S_MEM:    if (req.done) state_d = S_WB;
            default:  state_d = S_FETCH;
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_FETCH;
            busy_q  <= 1'b0;
        end else if (rdy_i) begin
            state_q <= state_d;
            if (req.start) begin
                busy_q <= 1'b1;
            end else if (req.done) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

// File: src/mem_req_if.sv
/* mem_req_if: one fetch, load or store request from the core to the byte port */
`timescale 1ns/100ps

interface mem_req_if import riscv_pkg::*; ();

    logic     start;
    logic     write;
    mem_len_e len;
    logic     sgn;
    word_t    addr;
    word_t    wdata;
    word_t    rdata;
    logic     done;

    // core side drives the request, port side answers
    modport core_mp (
        output start, write, len, sgn, addr, wdata,
        input  rdata, done
    );

    modport port_mp (
        input  start, write, len, sgn, addr, wdata,
        output rdata, done
    );

endinterface

// File: src/riscv_pkg.sv
/* riscv_pkg: widths, opcodes, ALU and transfer codes, and the instruction
   formats shared by the rv_core RTL */
package riscv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int BYTE_W     = 8;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [BYTE_W-1:0]     byte_t;

    localparam word_t RESET_PC = '0;

    // major opcodes, system opcode falls to the default no-op path
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_MISC   = 7'b0001111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd2
    } mem_len_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

endpackage
